//--- logic/decodePkg.sv
`default_nettype none

package decodePkg;

   typedef logic [15:0] word_t;      // data or instruction word
   typedef logic [2:0]  regAddr_t;   // one of eight general registers
   typedef logic [4:0]  opcode_t;    // instr[15:11]
   typedef logic [1:0]  func_t;      // instr[1:0]
   typedef logic [1:0]  resultSel_t;
   typedef logic [1:0]  immForm_t;

   // execute result source
   localparam resultSel_t selAluReg  = 2'd0;
   localparam resultSel_t selAluImm8 = 2'd1;
   localparam resultSel_t selAluImm5 = 2'd2;
   localparam resultSel_t selLink    = 2'd3;   // pc+2 into r7

   // immediate formats
   localparam immForm_t immForm5  = 2'd0;
   localparam immForm_t immForm8  = 2'd1;
   localparam immForm_t immForm11 = 2'd2;
   localparam immForm_t immNone   = 2'd3;

   localparam opcode_t opHalt  = 5'b00000;
   localparam opcode_t opNop   = 5'b00001;
   localparam opcode_t opSiic  = 5'b00010;   // trap opcode, raises illegal
   localparam opcode_t opRti   = 5'b00011;
   localparam opcode_t opJ     = 5'b00100;
   localparam opcode_t opJr    = 5'b00101;
   localparam opcode_t opJal   = 5'b00110;
   localparam opcode_t opJalr  = 5'b00111;
   localparam opcode_t opAddi  = 5'b01000;
   localparam opcode_t opSubi  = 5'b01001;
   localparam opcode_t opXori  = 5'b01010;
   localparam opcode_t opAndni = 5'b01011;
   localparam opcode_t opBeqz  = 5'b01100;
   localparam opcode_t opBnez  = 5'b01101;
   localparam opcode_t opBltz  = 5'b01110;
   localparam opcode_t opBgez  = 5'b01111;
   localparam opcode_t opSt    = 5'b10000;
   localparam opcode_t opLd    = 5'b10001;
   localparam opcode_t opSlbi  = 5'b10010;
   localparam opcode_t opStu   = 5'b10011;
   localparam opcode_t opRoli  = 5'b10100;
   localparam opcode_t opSlli  = 5'b10101;
   localparam opcode_t opRori  = 5'b10110;
   localparam opcode_t opSrli  = 5'b10111;
   localparam opcode_t opLbi   = 5'b11000;
   localparam opcode_t opBtr   = 5'b11001;
   localparam opcode_t opShift = 5'b11010;   // rol/sll/ror/srl by func
   localparam opcode_t opAdd   = 5'b11011;   // add/sub/xor/andn by func
   localparam opcode_t opSeq   = 5'b11100;
   localparam opcode_t opSlt   = 5'b11101;
   localparam opcode_t opSle   = 5'b11110;
   localparam opcode_t opSco   = 5'b11111;

   localparam word_t nopInstr = 16'h0800;

   typedef struct packed {
      logic       halt;
      logic       nop;
      logic       memRead;
      logic       memWrite;
      logic       memToReg;
      logic       branch;
      logic       jump;
      logic       jumpReg;    // target from rs plus imm
      logic       savePC;
      logic       regWrite;
      logic       illegal;
      resultSel_t resultSel;
      immForm_t   immForm;
      logic       zeroExt;
   } ctrl_t;

   typedef struct packed {
      logic     en;
      regAddr_t addr;
      word_t    data;
   } writeBack_t;

   typedef struct packed {
      word_t    rsData;
      word_t    rtData;
      word_t    imm;
      opcode_t  opcode;
      func_t    func;
      regAddr_t rs;
      regAddr_t rt;
      regAddr_t rd;
      ctrl_t    ctrl;
   } decodeOut_t;

   // control word of nopInstr, shared by decoder and flush path
   localparam ctrl_t nopCtrl = '{
      halt: 1'b0, nop: 1'b1, memRead: 1'b0, memWrite: 1'b0, memToReg: 1'b0,
      branch: 1'b0, jump: 1'b0, jumpReg: 1'b0, savePC: 1'b0, regWrite: 1'b0,
      illegal: 1'b0, resultSel: selAluReg, immForm: immNone, zeroExt: 1'b0
   };

   // decoded nopInstr with zero operands
   localparam decodeOut_t nopPacket = '{
      rsData: '0, rtData: '0, imm: '0,
      opcode: nopInstr[15:11], func: nopInstr[1:0],
      rs: nopInstr[10:8], rt: nopInstr[7:5], rd: nopInstr[4:2],
      ctrl: nopCtrl
   };

endpackage

`default_nettype wire

//--- logic/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
   input  decodePkg::word_t    instr,
   output decodePkg::ctrl_t    ctrl,
   output decodePkg::regAddr_t rs,
   output decodePkg::regAddr_t rt,
   output decodePkg::regAddr_t rd
);
   import decodePkg::*;

   opcode_t opcode;

   assign opcode = instr[15:11];
   assign rs     = instr[10:8];   // same position in every format
   assign rt     = instr[7:5];

   always_comb begin
      ctrl         = '0;
      ctrl.immForm = immNone;
      rd           = instr[4:2];   // register form

      case (opcode)
         opHalt: begin
            ctrl.halt = 1'b1;
         end
         opNop, opRti: begin
            ctrl = nopCtrl;          // rti has no exception path here
         end
         opSiic: begin
            ctrl         = nopCtrl;
            ctrl.illegal = 1'b1;
         end

         // 5-bit immediate alu ops, rd in bits 7:5
         opAddi, opSubi, opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = immForm5;
            ctrl.resultSel = selAluImm5;
            rd             = instr[7:5];
         end
         opXori, opAndni: begin
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = immForm5;
            ctrl.resultSel = selAluImm5;
            ctrl.zeroExt   = 1'b1;  // logical ops take unsigned imm
            rd             = instr[7:5];
         end

         // memory, address is rs + imm5
         opSt: begin
            ctrl.memWrite  = 1'b1;
            ctrl.immForm   = immForm5;
            ctrl.resultSel = selAluImm5;
            rd             = instr[7:5];
         end
         opLd: begin
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = immForm5;
            ctrl.resultSel = selAluImm5;
            rd             = instr[7:5];
         end
         opStu: begin
            ctrl.memWrite  = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = immForm5;
            ctrl.resultSel = selAluImm5;
            rd             = instr[10:8];   // updated base goes back to rs
         end

         opBtr, opAdd, opShift, opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrite  = 1'b1;
            ctrl.resultSel = selAluReg;
         end

         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.branch  = 1'b1;        // rs compared against zero
            ctrl.immForm = immForm8;
         end
         opLbi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = immForm8;
            ctrl.resultSel = selAluImm8;
            rd             = instr[10:8];
         end
         opSlbi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = immForm8;
            ctrl.resultSel = selAluImm8;
            ctrl.zeroExt   = 1'b1;      // low byte shifted in unsigned
            rd             = instr[10:8];
         end

         opJ: begin
            ctrl.jump    = 1'b1;
            ctrl.immForm = immForm11;
         end
         opJr: begin
            ctrl.jump    = 1'b1;
            ctrl.jumpReg = 1'b1;
            ctrl.immForm = immForm8;
         end
         opJal, opJalr: begin
            ctrl.jump      = 1'b1;
            ctrl.jumpReg   = (opcode == opJalr);
            ctrl.savePC    = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.immForm   = (opcode == opJalr) ? immForm8 : immForm11;
            ctrl.resultSel = selLink;
            rd             = 3'd7;      // link register
         end

         default: begin
            ctrl.illegal = 1'b1;        // regWrite stays low
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/regFileBypass.sv
`timescale 1ns/1ps
`default_nettype none

module regFileBypass (
   input  wire                  clk,
   input  wire                  reset,
   input  decodePkg::regAddr_t  rs,
   input  decodePkg::regAddr_t  rt,
   input  decodePkg::writeBack_t wb,
   output decodePkg::word_t     rsData,
   output decodePkg::word_t     rtData
);
   import decodePkg::*;

   word_t regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (wb.en) begin
         regs[wb.addr] <= wb.data;   // r0 is writable
      end
   end

   // writeback data wins over storage on an address match
   always_comb begin
      rsData = regs[rs];
      if (wb.en && (wb.addr == rs))
         rsData = wb.data;
   end

   always_comb begin
      rtData = regs[rt];
      if (wb.en && (wb.addr == rt))
         rtData = wb.data;
   end

endmodule

`default_nettype wire

//--- logic/idExRegister.sv
`timescale 1ns/1ps
`default_nettype none

module idExRegister (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   stall,
   input  wire                   branchTaken,
   input  decodePkg::word_t      instr,
   input  decodePkg::ctrl_t      ctrl,
   input  decodePkg::regAddr_t   rs,
   input  decodePkg::regAddr_t   rt,
   input  decodePkg::regAddr_t   rd,
   input  decodePkg::word_t      rsData,
   input  decodePkg::word_t      rtData,
   output decodePkg::decodeOut_t idEx
);
   import decodePkg::*;

   word_t      imm;
   decodeOut_t packet;

   always_comb begin
      case (ctrl.immForm)
         immForm5: begin
            if (ctrl.zeroExt)
               imm = {11'b0, instr[4:0]};
            else
               imm = {{11{instr[4]}}, instr[4:0]};
         end
         immForm8: begin
            if (ctrl.zeroExt)
               imm = {8'b0, instr[7:0]};
            else
               imm = {{8{instr[7]}}, instr[7:0]};
         end
         immForm11: begin
            imm = {{5{instr[10]}}, instr[10:0]};   // jump displacement, always signed
         end
         default: begin
            imm = '0;                              // register form
         end
      endcase
   end

   assign packet = '{
      rsData: rsData,
      rtData: rtData,
      imm:    imm,
      opcode: instr[15:11],
      func:   instr[1:0],
      rs:     rs,
      rt:     rt,
      rd:     rd,
      ctrl:   ctrl
   };

   always_ff @(posedge clk) begin
      if (reset || branchTaken)
         idEx <= nopPacket;   // flush beats stall
      else if (!stall)
         idEx <= packet;
   end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  wire                    clk,
   input  wire                    reset,
   input  decodePkg::word_t       instr,
   input  decodePkg::writeBack_t  wb,
   input  wire                    stall,
   input  wire                    branchTaken,
   output decodePkg::decodeOut_t  idEx
);
   import decodePkg::*;

   ctrl_t    ctrl;
   regAddr_t rs;
   regAddr_t rt;
   regAddr_t rd;
   word_t    rsData;
   word_t    rtData;

   controlDecoder u_controlDecoder (
      .instr (instr),
      .ctrl  (ctrl),
      .rs    (rs),
      .rt    (rt),
      .rd    (rd)
   );

   regFileBypass u_regFileBypass (
      .clk    (clk),
      .reset  (reset),
      .rs     (rs),
      .rt     (rt),
      .wb     (wb),
      .rsData (rsData),
      .rtData (rtData)
   );

   idExRegister u_idExRegister (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .branchTaken (branchTaken),
      .instr       (instr),
      .ctrl        (ctrl),
      .rs          (rs),
      .rt          (rt),
      .rd          (rd),
      .rsData      (rsData),
      .rtData      (rtData),
      .idEx        (idEx)
   );

endmodule

`default_nettype wire

//--- tests/decodeStage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageAsserts (
   input wire                   clk,
   input wire                   reset,
   input wire                   stall,
   input wire                   branchTaken,
   input decodePkg::decodeOut_t idEx
);

   int failCount = 0;   // failed assertions so far

   // reset loads the nop packet, nothing active
   resetQuiet: assert property (@(posedge clk)
      reset |=> !(idEx.ctrl.halt || idEx.ctrl.regWrite || idEx.ctrl.memWrite ||
                  idEx.ctrl.memRead || idEx.ctrl.branch || idEx.ctrl.jump ||
                  idEx.ctrl.illegal))
      else begin
         $error("control output active after reset");
         failCount++;
      end

   stallHolds: assert property (@(posedge clk) disable iff (reset)
      stall && !branchTaken |=> $stable(idEx))
      else begin
         $error("idEx changed under stall");
         failCount++;
      end

   flushNop: assert property (@(posedge clk) disable iff (reset)
      branchTaken |=> idEx.ctrl.nop)
      else begin
         $error("idEx not a nop after branchTaken");
         failCount++;
      end

   illegalNoWrite: assert property (@(posedge clk) disable iff (reset)
      idEx.ctrl.illegal |-> !idEx.ctrl.regWrite)   // no writeback on trap
      else begin
         $error("illegal instruction with regWrite set");
         failCount++;
      end

endmodule

bind decodeStage decodeStageAsserts u_decodeStageAsserts (
   .clk         (clk),
   .reset       (reset),
   .stall       (stall),
   .branchTaken (branchTaken),
   .idEx        (idEx)
);

`default_nettype wire

//--- tests/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;
   import decodePkg::*;

   localparam int waitLimit = 20;

   logic       clk;
   logic       reset;
   word_t      instr;
   writeBack_t wb;
   logic       stall;
   logic       branchTaken;
   decodeOut_t idEx;

   integer seed;
   word_t  regModel [8];   // expected register contents

   decodeStage u_decodeStage (
      .clk         (clk),
      .reset       (reset),
      .instr       (instr),
      .wb          (wb),
      .stall       (stall),
      .branchTaken (branchTaken),
      .idEx        (idEx)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check(input string name, input logic [95:0] expected,
                        input logic [95:0] actual);
      if (actual !== expected) begin
         $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // after reset idEx must settle on the nop packet
   task automatic waitForNop();
      int cycles;
      cycles = 0;
      while (idEx.ctrl.nop !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > waitLimit) begin
            $display("timeout: idEx never showed the nop packet after reset");
            $display("Simulation FAILED");
            $fatal(1, "wait ran out");
         end
      end
   endtask

   function automatic word_t regForm(opcode_t op, regAddr_t rs, regAddr_t rt, regAddr_t rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic word_t imm5Form(opcode_t op, regAddr_t rs, regAddr_t rd,
                                      logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t imm8Form(opcode_t op, regAddr_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t imm11Form(opcode_t op, logic [10:0] disp);
      return {op, disp};
   endfunction

   // halt memRead memWrite memToReg branch jump savePC regWrite illegal
   function automatic logic [8:0] flagsOf(decodeOut_t p);
      return {p.ctrl.halt, p.ctrl.memRead, p.ctrl.memWrite, p.ctrl.memToReg,
              p.ctrl.branch, p.ctrl.jump, p.ctrl.savePC, p.ctrl.regWrite,
              p.ctrl.illegal};
   endfunction

   // one instruction in, result sampled one edge later
   task automatic issue(input word_t word, input writeBack_t write);
      @(posedge clk);
      instr <= word;
      wb    <= write;
      @(posedge clk);   // decode captured here
      wb    <= '0;
      @(negedge clk);
   endtask

   task automatic testResetAndRegs();
      regAddr_t other;
      check("idEx.opcode", opNop, idEx.opcode);
      check("idEx control flags", 9'b0, flagsOf(idEx));
      for (int r = 0; r < 8; r++) begin
         other = regAddr_t'(r + 1);
         issue(regForm(opAdd, regAddr_t'(r), other, 3'd1), '0);
         check("idEx.rsData", 16'h0, idEx.rsData);
         check("idEx.rtData", 16'h0, idEx.rtData);
      end
      for (int r = 0; r < 8; r++) begin
         regModel[r] = word_t'($random(seed));
         issue(nopInstr, {1'b1, regAddr_t'(r), regModel[r]});
      end
      for (int r = 0; r < 8; r++) begin
         other = regAddr_t'(7 - r);
         issue(regForm(opAdd, regAddr_t'(r), other, 3'd2), '0);
         check("idEx.rt", other, idEx.rt);
         check("idEx.rsData", regModel[r], idEx.rsData);
         check("idEx.rtData", regModel[other], idEx.rtData);
      end
   endtask

   task automatic testBypass();
      word_t fresh;
      fresh = word_t'($random(seed));
      issue(regForm(opAdd, 3'd3, 3'd5, 3'd1), {1'b1, 3'd3, fresh});   // rs hit
      regModel[3] = fresh;
      check("idEx.rsData", fresh, idEx.rsData);
      check("idEx.rtData", regModel[5], idEx.rtData);
      fresh = word_t'($random(seed));
      issue(regForm(opAdd, 3'd6, 3'd0, 3'd2), {1'b1, 3'd0, fresh});   // rt hit on r0
      regModel[0] = fresh;
      check("idEx.rtData", fresh, idEx.rtData);
      check("idEx.rsData", regModel[6], idEx.rsData);
   endtask

   task automatic testImmediates();
      issue(imm5Form(opAddi, 3'd2, 3'd4, 5'h16), '0);
      check("idEx.imm", 16'hfff6, idEx.imm);
      check("idEx.rd", 3'd4, idEx.rd);
      check("idEx.rs", 3'd2, idEx.rs);
      check("idEx.opcode", opAddi, idEx.opcode);
      issue(imm5Form(opXori, 3'd5, 3'd1, 5'h16), '0);
      check("idEx.imm", 16'h0016, idEx.imm);   // logical op, no sign
      check("idEx.rd", 3'd1, idEx.rd);
      check("idEx.func", 2'b10, idEx.func);   // low bits of the imm field
      issue(imm8Form(opLbi, 3'd6, 8'h9c), '0);
      check("idEx.imm", 16'hff9c, idEx.imm);
      check("idEx.rd", 3'd6, idEx.rd);
      issue(imm11Form(opJ, 11'h5a3), '0);
      check("idEx.imm", 16'hfda3, idEx.imm);
      check("idEx.opcode", opJ, idEx.opcode);
      check("idEx.ctrl.immForm", immForm11, idEx.ctrl.immForm);
   endtask

   task automatic testControl();
      issue(imm5Form(opLd, 3'd1, 3'd2, 5'h04), '0);
      check("ld flags", 9'b010100010, flagsOf(idEx));
      issue(imm5Form(opSt, 3'd1, 3'd2, 5'h04), '0);
      check("st flags", 9'b001000000, flagsOf(idEx));
      issue(imm8Form(opBeqz, 3'd3, 8'h10), '0);
      check("beqz flags", 9'b000010000, flagsOf(idEx));
      issue(imm11Form(opJal, 11'h020), '0);
      check("jal flags", 9'b000001110, flagsOf(idEx));
      check("idEx.rd", 3'd7, idEx.rd);   // link register
      check("idEx.ctrl.resultSel", selLink, idEx.ctrl.resultSel);
      check("idEx.ctrl.jumpReg", 1'b0, idEx.ctrl.jumpReg);
      issue(16'h0000, '0);
      check("halt flags", 9'b100000000, flagsOf(idEx));
      issue({opSiic, 11'h0}, '0);   // no instruction behind this opcode here
      check("unused opcode flags", 9'b000000001, flagsOf(idEx));
   endtask

   task automatic testStallFlush();
      issue(regForm(opAdd, 3'd1, 3'd2, 3'd3), '0);
      @(posedge clk);
      stall <= 1'b1;
      instr <= imm8Form(opLbi, 3'd4, 8'h55);
      repeat (2) @(posedge clk);
      @(negedge clk);
      check("idEx.opcode", opAdd, idEx.opcode);   // add still held
      check("idEx.rd", 3'd3, idEx.rd);
      check("idEx.rsData", regModel[1], idEx.rsData);
      check("idEx.rtData", regModel[2], idEx.rtData);
      @(posedge clk);
      branchTaken <= 1'b1;   // stall still high
      @(posedge clk);
      branchTaken <= 1'b0;
      stall       <= 1'b0;
      @(negedge clk);
      check("idEx.opcode", opNop, idEx.opcode);
      check("idEx.ctrl.nop", 1'b1, idEx.ctrl.nop);
      check("flushed flags", 9'b0, flagsOf(idEx));
      check("idEx.rsData", 16'h0, idEx.rsData);
      check("idEx.rtData", 16'h0, idEx.rtData);
      check("idEx.imm", 16'h0, idEx.imm);
   endtask

   initial begin
      seed        = 32'h854c;
      reset       = 1'b1;
      instr       = nopInstr;
      wb          = '0;
      stall       = 1'b0;
      branchTaken = 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      waitForNop();
      testResetAndRegs();
      testBypass();
      testImmediates();
      testControl();
      testStallFlush();
      repeat (2) @(negedge clk);   // let pending assertions complete
      if (u_decodeStage.u_decodeStageAsserts.failCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- decodeStage.f
logic/decodePkg.sv
logic/controlDecoder.sv
logic/regFileBypass.sv
logic/idExRegister.sv
logic/decodeStage.sv
tests/decodeStage_asserts.sv
tests/decodeStageTb.sv
